//--- Bender.yml
package:
  name: frame_display

sources:
  - fb_pkg.sv
  - pixel_packer.sv
  - frame_store.sv
  - video_timing.sv
  - scanout.sv
  - frame_display_top.sv
  - target: test
    files:
      - fb_assert.sv
      - tb_frame_display.sv

//--- fb_assert.sv
/*
 * fb_assert
 * port, overflow and clear sweep checks bound into frame_store
 */
`default_nettype none

module fb_assert #(
   parameter int ADDR_W = 10
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                read_en,
   input  logic                clearing,
   input  logic                overflow,
   input  logic [ADDR_W-1:0]   mem_waddr,
   input  logic [ADDR_W-1:0]   sweep_addr,
   input  fb_pkg::word_t       mem [2**ADDR_W]
);
   timeunit 1ns;
   timeprecision 100ps;

   // failed assertions, read by the testbench at the end of the run
   int unsigned fail_count = 0;

   // a read owns the memory port in its cycle
   // the word at the write port address keeps its value
   a_no_write_on_read: assert property (@(posedge clk) disable iff (!rst_n)
      read_en |=> mem[$past(mem_waddr)] === $past(mem[mem_waddr]))
   else begin
      $error("memory array written in a read_en cycle");
      fail_count++;
   end

   // sticky flag, only reset clears it
   a_overflow_sticky: assert property (@(posedge clk)
      (rst_n && overflow) |=> overflow)
   else begin
      $error("overflow fell without reset");
      fail_count++;
   end

   // queued words wait for the end of the sweep
   // every free cycle of a clear zeroes the sweep position
   a_no_queue_during_clear: assert property (@(posedge clk) disable iff (!rst_n)
      (clearing && !read_en) |=> mem[$past(sweep_addr)] === '0)
   else begin
      $error("queue word written while clearing");
      fail_count++;
   end

endmodule

bind frame_store fb_assert #(
   .ADDR_W (ADDR_W)
) i_fb_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .read_en    (read_en),
   .clearing   (clearing),
   .overflow   (overflow),
   .mem_waddr  (mem_waddr),
   .sweep_addr (sweep_addr),
   .mem        (mem)
);

`default_nettype wire

//--- fb_pkg.sv
/*
 * fb_pkg
 * shared pixel, word, phase and counter types and the fixed memory
 * constants of the frame buffer
 */
`default_nettype none

package fb_pkg;

   ////////////////////////////////////////
   // types
   ////////////////////////////////////////

   // one greyscale pixel
   typedef logic [7:0] pixel_t;

   // one memory word, four pixels with the earliest in the low byte
   // top nibble is unused and always written as zero
   typedef logic [35:0] word_t;

   // column position inside a four column group
   typedef logic [1:0] phase_t;

   // display column and line count, wide enough for any total used here
   typedef logic [10:0] count_t;

   ////////////////////////////////////////
   // constants
   ////////////////////////////////////////

   localparam int PIX_PER_WORD = 4;
   localparam int PIX_W = $bits(pixel_t);

   // scanout issues its read at this phase
   localparam phase_t READ_PHASE = 2'd0;

   // cycles from read request to read data
   localparam int RAM_LATENCY = 2;

endpackage

`default_nettype wire

//--- files.f
fb_pkg.sv
pixel_packer.sv
frame_store.sv
video_timing.sv
scanout.sv
frame_display_top.sv
fb_assert.sv
tb_frame_display.sv

//--- frame_display_top.sv
/*
 * frame_display_top
 * single clock frame buffer, pixel packer into frame store, scanned out
 * under the display timing
 */
`default_nettype none

module frame_display_top #(
   parameter int H_ACTIVE    = 64,
   parameter int H_TOTAL     = 80,
   parameter int V_ACTIVE    = 48,
   parameter int V_TOTAL     = 56,
   parameter int ADDR_W      = 10,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            pixel_valid,
   input  fb_pkg::pixel_t  pixel,
   input  logic            frame_start,
   input  logic            clear_req,
   output fb_pkg::pixel_t  vid_pixel,
   output logic            vid_hsync,
   output logic            vid_vsync,
   output logic            vid_blank,
   output logic            clearing,
   output logic            overflow
);
   import fb_pkg::*;

   // packer to store
   logic                word_valid;
   word_t               word;
   logic [ADDR_W-1:0]   word_addr;

   // scanout read port
   logic                read_en;
   logic [ADDR_W-1:0]   read_addr;
   word_t               read_data;

   // display timing
   count_t              hcount;
   count_t              vcount;
   logic                hsync;
   logic                vsync;
   logic                blank;

   pixel_packer #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .ADDR_W   (ADDR_W)
   ) i_pixel_packer (
      .clk         (clk),
      .rst_n       (rst_n),
      .pixel_valid (pixel_valid),
      .pixel       (pixel),
      .frame_start (frame_start),
      .word_valid  (word_valid),
      .word        (word),
      .word_addr   (word_addr)
   );

   frame_store #(
      .ADDR_W      (ADDR_W),
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .H_ACTIVE    (H_ACTIVE),
      .V_ACTIVE    (V_ACTIVE)
   ) i_frame_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .word_valid (word_valid),
      .word       (word),
      .word_addr  (word_addr),
      .clear_req  (clear_req),
      .read_en    (read_en),
      .read_addr  (read_addr),
      .read_data  (read_data),
      .clearing   (clearing),
      .overflow   (overflow)
   );

   video_timing #(
      .H_ACTIVE (H_ACTIVE),
      .H_TOTAL  (H_TOTAL),
      .V_ACTIVE (V_ACTIVE),
      .V_TOTAL  (V_TOTAL)
   ) i_video_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   scanout #(
      .H_ACTIVE (H_ACTIVE),
      .ADDR_W   (ADDR_W)
   ) i_scanout (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .vcount    (vcount),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .read_data (read_data),
      .read_en   (read_en),
      .read_addr (read_addr),
      .vid_pixel (vid_pixel),
      .vid_hsync (vid_hsync),
      .vid_vsync (vid_vsync),
      .vid_blank (vid_blank)
   );

endmodule

`default_nettype wire

//--- frame_store.sv
/*
 * frame_store
 * frame memory with a small write queue and a clear sweep
 * reads always win the port, writes use the free cycles
 */
`default_nettype none

module frame_store #(
   parameter int ADDR_W      = 10,
   parameter int QUEUE_DEPTH = 4,
   parameter int H_ACTIVE    = 64,
   parameter int V_ACTIVE    = 48
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                word_valid,
   input  fb_pkg::word_t       word,
   input  logic [ADDR_W-1:0]   word_addr,
   input  logic                clear_req,
   input  logic                read_en,
   input  logic [ADDR_W-1:0]   read_addr,
   output fb_pkg::word_t       read_data,
   output logic                clearing,
   output logic                overflow
);
   import fb_pkg::*;

   localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_WORDS - 1);
   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
   localparam int MEM_WORDS = 2 ** ADDR_W;

   // write queue
   word_t               q_data [QUEUE_DEPTH];
   logic [ADDR_W-1:0]   q_addr [QUEUE_DEPTH];
   logic [PTR_W-1:0]    q_wr_ptr;
   logic [PTR_W-1:0]    q_rd_ptr;
   logic [CNT_W-1:0]    q_count;
   logic                q_full;
   logic                q_empty;
   logic                q_push;
   logic                q_pop;

   // clear sweep position
   logic [ADDR_W-1:0]   sweep_addr;

   // memory port
   logic                mem_we;
   logic [ADDR_W-1:0]   mem_waddr;
   word_t               mem_wdata;
   word_t               mem [MEM_WORDS];
   word_t               rd_pipe [RAM_LATENCY];

   ////////////////////////////////////////
   // arbitration
   ////////////////////////////////////////

   assign q_full  = (q_count == CNT_W'(QUEUE_DEPTH));
   assign q_empty = (q_count == '0);

   // packer is never stalled, a word hitting a full queue is dropped
   assign q_push = word_valid && !q_full;

   // queue head drains only when no read and no sweep
   assign q_pop = !read_en && !clearing && !q_empty;

   // read first, then sweep, then queue head
   assign mem_we    = !read_en && (clearing || !q_empty);
   assign mem_waddr = clearing ? sweep_addr : q_addr[q_rd_ptr];
   assign mem_wdata = clearing ? '0 : q_data[q_rd_ptr];

   ////////////////////////////////////////
   // write queue
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q_wr_ptr <= '0;
         q_rd_ptr <= '0;
         q_count  <= '0;
      end else begin
         if (q_push) begin
            q_wr_ptr <= (q_wr_ptr == LAST_PTR) ? '0 : q_wr_ptr + 1'b1;
         end
         if (q_pop) begin
            q_rd_ptr <= (q_rd_ptr == LAST_PTR) ? '0 : q_rd_ptr + 1'b1;
         end
         case ({q_push, q_pop})
            2'b10:   q_count <= q_count + 1'b1;
            2'b01:   q_count <= q_count - 1'b1;
            default: q_count <= q_count;
         endcase
      end
   end

   // queue entries
   always_ff @(posedge clk) begin
      if (q_push) begin
         q_data[q_wr_ptr] <= word;
         q_addr[q_wr_ptr] <= word_addr;
      end
   end

   // sticky until reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         overflow <= 1'b0;
      end else if (word_valid && q_full) begin
         overflow <= 1'b1;
      end
   end

   ////////////////////////////////////////
   // clear sweep
   ////////////////////////////////////////

   // one zero word per free cycle, from address 0 up to the last frame word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clearing   <= 1'b0;
         sweep_addr <= '0;
      end else if (clear_req) begin
         clearing   <= 1'b1;
         sweep_addr <= '0;
      end else if (clearing && !read_en) begin
         if (sweep_addr == LAST_ADDR) begin
            clearing <= 1'b0;
         end else begin
            sweep_addr <= sweep_addr + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // word array
   ////////////////////////////////////////

   // synchronous array, read data goes through RAM_LATENCY registers
   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_waddr] <= mem_wdata;
      end
      if (read_en) begin
         rd_pipe[0] <= mem[read_addr];
      end
      for (int i = 1; i < RAM_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign read_data = rd_pipe[RAM_LATENCY-1];

endmodule

`default_nettype wire

//--- pixel_packer.sv
/*
 * pixel_packer
 * packs the incoming pixel stream four to a memory word and hands each
 * full word out with its linear frame address
 */
`default_nettype none

module pixel_packer #(
   parameter int H_ACTIVE = 64,
   parameter int V_ACTIVE = 48,
   parameter int ADDR_W   = 10
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                pixel_valid,
   input  fb_pkg::pixel_t      pixel,
   input  logic                frame_start,
   output logic                word_valid,
   output fb_pkg::word_t       word,
   output logic [ADDR_W-1:0]   word_addr
);
   import fb_pkg::*;

   localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_WORDS - 1);
   // bytes held back until the fourth pixel shows up
   localparam int HOLD_W = (PIX_PER_WORD - 1) * PIX_W;
   localparam int PAD_W = $bits(word_t) - PIX_PER_WORD * PIX_W;

   phase_t              phase;
   logic [HOLD_W-1:0]   hold;
   logic [ADDR_W-1:0]   addr;
   logic                last_pix;

   ////////////////////////////////////////
   // word output
   ////////////////////////////////////////

   // current pixel completes a word
   assign last_pix = (phase == phase_t'(PIX_PER_WORD - 1));

   // word leaves in the same cycle as its fourth pixel
   // frame_start takes priority and throws the partial word away
   assign word_valid = pixel_valid && last_pix && !frame_start;
   assign word       = {{PAD_W{1'b0}}, pixel, hold};
   assign word_addr  = addr;

   ////////////////////////////////////////
   // phase and address counters
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase <= '0;
         addr  <= '0;
      end else if (frame_start) begin
         // restart at word 0
         // a pixel in this cycle becomes byte 0 of that word
         phase <= pixel_valid ? phase_t'(1) : '0;
         addr  <= '0;
      end else if (pixel_valid) begin
         // phase wraps from 3 back to 0 by itself
         phase <= phase + 1'b1;
         if (last_pix) begin
            // wrap after the last word of the frame
            addr <= (addr == LAST_ADDR) ? '0 : addr + 1'b1;
         end
      end
   end

   // pixel hold register, newest byte enters at the top
   // after three pixels the earliest sits in the low byte
   always_ff @(posedge clk) begin
      if (pixel_valid) begin
         hold <= {pixel, hold[HOLD_W-1:PIX_W]};
      end
   end

endmodule

`default_nettype wire

//--- scanout.sv
/*
 * scanout
 * reads one frame word per four active columns, unpacks it a byte per
 * column and keeps syncs and blank aligned with the pixel
 */
`default_nettype none

module scanout #(
   parameter int H_ACTIVE = 64,
   parameter int ADDR_W   = 10
) (
   input  logic                clk,
   input  logic                rst_n,
   input  fb_pkg::count_t      hcount,
   input  fb_pkg::count_t      vcount,
   input  logic                hsync,
   input  logic                vsync,
   input  logic                blank,
   input  fb_pkg::word_t       read_data,
   output logic                read_en,
   output logic [ADDR_W-1:0]   read_addr,
   output fb_pkg::pixel_t      vid_pixel,
   output logic                vid_hsync,
   output logic                vid_vsync,
   output logic                vid_blank
);
   import fb_pkg::*;

   localparam int WORDS_PER_LINE = H_ACTIVE / PIX_PER_WORD;
   // request reg + memory + capture + pixel reg
   localparam int PIPE_LEN = RAM_LATENCY + 3;

   phase_t                 col_phase;
   logic                   issue;
   logic [ADDR_W-1:0]      group_addr;
   logic [RAM_LATENCY-1:0] rd_vld;
   logic                   load;
   word_t                  shift_word;
   logic [PIPE_LEN-1:0]    hs_pipe;
   logic [PIPE_LEN-1:0]    vs_pipe;
   logic [PIPE_LEN-1:0]    bl_pipe;

   ////////////////////////////////////////
   // read request
   ////////////////////////////////////////

   assign col_phase = hcount[1:0];

   // blank low means hcount and vcount are inside the active area
   assign issue = !blank && (col_phase == READ_PHASE);

   // word index of this column group
   assign group_addr = ADDR_W'(int'(vcount) * WORDS_PER_LINE + int'(hcount) / PIX_PER_WORD);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         read_en <= 1'b0;
      end else begin
         read_en <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         read_addr <= group_addr;
      end
   end

   ////////////////////////////////////////
   // unpack
   ////////////////////////////////////////

   // marks the cycle the requested word is on read_data
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_vld <= '0;
      end else begin
         rd_vld <= {rd_vld[RAM_LATENCY-2:0], read_en};
      end
   end

   assign load = rd_vld[RAM_LATENCY-1];

   // earliest pixel first, one byte per column
   always_ff @(posedge clk) begin
      if (load) begin
         shift_word <= read_data;
      end else begin
         shift_word <= shift_word >> PIX_W;
      end
   end

   ////////////////////////////////////////
   // sync and blank alignment
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hs_pipe <= '1;
         vs_pipe <= '1;
         bl_pipe <= '1;
      end else begin
         hs_pipe <= {hs_pipe[PIPE_LEN-2:0], hsync};
         vs_pipe <= {vs_pipe[PIPE_LEN-2:0], vsync};
         bl_pipe <= {bl_pipe[PIPE_LEN-2:0], blank};
      end
   end

   // pixel register sits in the last stage, blank columns give zero
   always_ff @(posedge clk) begin
      vid_pixel <= bl_pipe[PIPE_LEN-2] ? '0 : shift_word[PIX_W-1:0];
   end

   assign vid_hsync = hs_pipe[PIPE_LEN-1];
   assign vid_vsync = vs_pipe[PIPE_LEN-1];
   assign vid_blank = bl_pipe[PIPE_LEN-1];

endmodule

`default_nettype wire

//--- tb_frame_display.sv
/*
 * tb_frame_display
 * directed tests for the frame buffer, compares the scanned out picture
 * with a pixel model of the frame memory
 */
`default_nettype none

module tb_frame_display;
   timeunit 1ns;
   timeprecision 100ps;

   import fb_pkg::*;

   localparam int H_ACTIVE    = 64;
   localparam int H_TOTAL     = 80;
   localparam int V_ACTIVE    = 48;
   localparam int V_TOTAL     = 56;
   localparam int FRAME_PIX   = H_ACTIVE * V_ACTIVE;
   localparam int FRAME_WORDS = FRAME_PIX / PIX_PER_WORD;
   // reads take at most a quarter of the cycles
   localparam int SWEEP_LIMIT = 2 * FRAME_WORDS;
   // about 13 frames of writing and checking, rounded up
   localparam int FRAMES_USED = 15;
   localparam int TIMEOUT_CYCLES = FRAMES_USED * V_TOTAL * H_TOTAL + 2 * SWEEP_LIMIT + 2000;

   logic    clk = 1'b0;
   logic    rst_n;
   logic    pixel_valid;
   pixel_t  pixel;
   logic    frame_start;
   logic    clear_req;
   pixel_t  vid_pixel;
   logic    vid_hsync;
   logic    vid_vsync;
   logic    vid_blank;
   logic    clearing;
   logic    overflow;

   integer  seed = 48792;
   int      errors = 0;
   int      cycles = 0;

   // frame model, one pixel per display position
   pixel_t  model_frame [FRAME_PIX];
   // partial word not yet in memory
   pixel_t  stage [PIX_PER_WORD];
   int      stage_cnt = 0;
   int      stage_word = 0;

   frame_display_top i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .pixel_valid (pixel_valid),
      .pixel       (pixel),
      .frame_start (frame_start),
      .clear_req   (clear_req),
      .vid_pixel   (vid_pixel),
      .vid_hsync   (vid_hsync),
      .vid_vsync   (vid_vsync),
      .vid_blank   (vid_blank),
      .clearing    (clearing),
      .overflow    (overflow)
   );

   always #5 clk = ~clk;

   // watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("timeout, run stopped after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
      if (act !== exp) begin
         errors++;
         $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("Fail t=%0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   ////////////////////////////////////////
   // stimulus and model
   ////////////////////////////////////////

   // inputs change 1 ns after the rising edge
   task automatic advance_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_idle();
      pixel_valid = 1'b0;
      pixel       = '0;
      frame_start = 1'b0;
      clear_req   = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         advance_cycle();
         drive_idle();
      end
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      drive_idle();
      repeat (2) advance_cycle();
      rst_n = 1'b1;
      stage_cnt  = 0;
      stage_word = 0;
   endtask

   // packing rule, a word reaches the frame only with its fourth pixel
   function automatic void model_accept(input pixel_t p, input logic fs);
      if (fs) begin
         stage_cnt  = 0;
         stage_word = 0;
      end
      stage[stage_cnt] = p;
      stage_cnt++;
      if (stage_cnt == PIX_PER_WORD) begin
         for (int k = 0; k < PIX_PER_WORD; k++) begin
            model_frame[stage_word * PIX_PER_WORD + k] = stage[k];
         end
         stage_cnt  = 0;
         stage_word = (stage_word == FRAME_WORDS - 1) ? 0 : stage_word + 1;
      end
   endfunction

   task automatic send_pixel(input pixel_t p, input logic fs);
      advance_cycle();
      pixel_valid = 1'b1;
      pixel       = p;
      frame_start = fs;
      model_accept(p, fs);
   endtask

   task automatic wait_clear_done();
      int n;
      n = 0;
      while (clearing === 1'b1 && n < SWEEP_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (clearing !== 1'b0) begin
         errors++;
         $display("t=%0t clearing still high after %0d cycles", $time, SWEEP_LIMIT);
      end
   endtask

   // outputs are sampled on the falling edge
   task automatic check_frame();
      int   v;
      int   c;
      logic hs_seen;
      @(negedge clk);
      // line 0 follows the end of vsync
      while (vid_vsync !== 1'b0) @(negedge clk);
      while (vid_vsync !== 1'b1) @(negedge clk);
      for (v = 0; v < V_ACTIVE; v++) begin
         while (vid_blank !== 1'b0) @(negedge clk);
         for (c = 0; c < H_ACTIVE; c++) begin
            check_flag("vid_blank", 1'b0, vid_blank);
            check_flag("vid_hsync", 1'b1, vid_hsync);
            check_flag("vid_vsync", 1'b1, vid_vsync);
            check_pixel("vid_pixel", model_frame[v * H_ACTIVE + c], vid_pixel);
            @(negedge clk);
         end
         // blank columns show zero, hsync pulses somewhere inside them
         hs_seen = 1'b0;
         for (c = H_ACTIVE; c < H_TOTAL; c++) begin
            check_flag("vid_blank", 1'b1, vid_blank);
            check_pixel("vid_pixel", '0, vid_pixel);
            if (vid_hsync === 1'b0) begin
               hs_seen = 1'b1;
            end
            @(negedge clk);
         end
         if (!hs_seen) begin
            errors++;
            $display("t=%0t no hsync pulse in the blanking after line %0d", $time, v);
         end
      end
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic test_reset_state();
      int n;
      @(negedge clk);
      check_flag("vid_blank", 1'b1, vid_blank);
      n = 0;
      while (vid_blank === 1'b1 && n < H_TOTAL) begin
         check_flag("clearing", 1'b0, clearing);
         check_flag("overflow", 1'b0, overflow);
         check_flag("vid_hsync", 1'b1, vid_hsync);
         check_flag("vid_vsync", 1'b1, vid_vsync);
         n++;
         @(negedge clk);
      end
      if (vid_blank !== 1'b0) begin
         errors++;
         $display("t=%0t vid_blank did not fall within one line after reset", $time);
      end
   endtask

   task automatic test_ramp_frame();
      for (int p = 0; p < FRAME_PIX; p++) begin
         send_pixel(pixel_t'(p), p == 0);
      end
      idle_cycles(8);
      check_frame();
   endtask

   task automatic test_random_frame();
      for (int p = 0; p < FRAME_PIX; p++) begin
         send_pixel(pixel_t'($random(seed)), p == 0);
         idle_cycles({$random(seed)} % 4);
      end
      idle_cycles(8);
      check_frame();
      check_flag("overflow", 1'b0, overflow);
   endtask

   // two stray pixels, then a restart
   task automatic test_mid_word();
      send_pixel(8'ha5, 1'b0);
      send_pixel(8'h5a, 1'b0);
      for (int p = 0; p < FRAME_PIX; p++) begin
         send_pixel(pixel_t'(p * 7 + 3), p == 0);
      end
      idle_cycles(8);
      check_frame();
   endtask

   task automatic test_clear();
      advance_cycle();
      clear_req = 1'b1;
      @(negedge clk);
      check_flag("clearing", 1'b0, clearing);
      advance_cycle();
      clear_req = 1'b0;
      @(negedge clk);
      check_flag("clearing", 1'b1, clearing);
      wait_clear_done();
      for (int i = 0; i < FRAME_PIX; i++) begin
         model_frame[i] = '0;
      end
      check_frame();
   endtask

   // 16 words against a 4 entry queue held by the sweep
   task automatic test_overflow();
      advance_cycle();
      clear_req = 1'b1;
      for (int p = 0; p < 64; p++) begin
         send_pixel(pixel_t'($random(seed)), 1'b0);
         clear_req = 1'b0;
      end
      idle_cycles(1);
      @(negedge clk);
      check_flag("overflow", 1'b1, overflow);
      wait_clear_done();
      check_flag("clearing", 1'b0, clearing);
      idle_cycles(4);
      @(negedge clk);
      check_flag("overflow", 1'b1, overflow);
      apply_reset();
      @(negedge clk);
      check_flag("overflow", 1'b0, overflow);
      check_flag("clearing", 1'b0, clearing);
   endtask

   initial begin
      int assert_fails;
      apply_reset();
      test_reset_state();
      test_ramp_frame();
      test_random_frame();
      test_mid_word();
      test_clear();
      test_overflow();
      assert_fails = i_dut.i_frame_store.i_fb_assert.fail_count;
      $display("errors: %0d failed checks, %0d failed assertions", errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- video_timing.sv
/*
 * video_timing
 * column and line counters with blank and active low sync windows
 * all outputs registered one cycle after the counters
 */
`default_nettype none

module video_timing #(
   parameter int H_ACTIVE = 64,
   parameter int H_TOTAL  = 80,
   parameter int V_ACTIVE = 48,
   parameter int V_TOTAL  = 56
) (
   input  logic            clk,
   input  logic            rst_n,
   output fb_pkg::count_t  hcount,
   output fb_pkg::count_t  vcount,
   output logic            hsync,
   output logic            vsync,
   output logic            blank
);
   import fb_pkg::*;

   // syncs sit in the middle half of each blanking interval
   localparam int H_SYNC_START = H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4;
   localparam int H_SYNC_END   = H_SYNC_START + (H_TOTAL - H_ACTIVE) / 2;
   localparam int V_SYNC_START = V_ACTIVE + (V_TOTAL - V_ACTIVE) / 4;
   localparam int V_SYNC_END   = V_SYNC_START + (V_TOTAL - V_ACTIVE) / 2;

   count_t  h_cnt;
   count_t  v_cnt;
   logic    h_last;
   logic    v_last;
   logic    active;
   logic    hsync_win;
   logic    vsync_win;

   ////////////////////////////////////////
   // counters
   ////////////////////////////////////////

   assign h_last = (h_cnt == count_t'(H_TOTAL - 1));
   assign v_last = (v_cnt == count_t'(V_TOTAL - 1));

   // 0 is the first active column and line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_last) begin
         h_cnt <= '0;
         v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // window decode
   ////////////////////////////////////////

   assign active = (h_cnt < count_t'(H_ACTIVE)) && (v_cnt < count_t'(V_ACTIVE));

   assign hsync_win = (h_cnt >= count_t'(H_SYNC_START)) && (h_cnt < count_t'(H_SYNC_END));
   assign vsync_win = (v_cnt >= count_t'(V_SYNC_START)) && (v_cnt < count_t'(V_SYNC_END));

   // output registers, syncs active low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b1;
      end else begin
         hcount <= h_cnt;
         vcount <= v_cnt;
         hsync  <= !hsync_win;
         vsync  <= !vsync_win;
         blank  <= !active;
      end
   end

endmodule

`default_nettype wire
